/* source/core_cfg_pkg.sv */
package core_cfg_pkg;

  // datapath width of every register value
  localparam int xlen = 32;

  // arch registers occupy indices 0 to num_arch-1
  localparam int num_arch = 32;

  // default size of the rename pool, placed directly above the arch registers
  localparam int num_rename = 32;

  // total index space covered by a register index
  localparam int num_idx = num_arch + num_rename;

  // 0 to 31 select arch registers, 32 to 63 select rename registers
  typedef logic [5:0] reg_idx_t;

  // arch register number as seen by decode
  typedef logic [4:0] arch_idx_t;

endpackage

/* source/rename_bus_pkg.sv */
package rename_bus_pkg;

  // one rename slot from decode
  typedef struct packed {
    logic                   valid;
    core_cfg_pkg::arch_idx_t rd;
    core_cfg_pkg::arch_idx_t rs1;
    core_cfg_pkg::arch_idx_t rs2;
    logic                   spec;   // issued behind an unresolved branch
  } rename_req_t;

  // source operand as handed to the reservation stations
  typedef struct packed {
    logic                           ready;  // value can be used right away
    core_cfg_pkg::reg_idx_t          tag;    // rename register to wait on when not ready
    logic [core_cfg_pkg::xlen-1:0]  value;
  } operand_t;

  // answer to one rename slot, valid in the same cycle as the request
  typedef struct packed {
    logic                  grant;
    core_cfg_pkg::reg_idx_t pd;
    operand_t              src1;
    operand_t              src2;
  } rename_rsp_t;

  // result broadcast from an execution unit
  typedef struct packed {
    logic                           valid;
    core_cfg_pkg::reg_idx_t          pd;
    logic [core_cfg_pkg::xlen-1:0]  value;
  } wb_t;

  // in-order retirement from the reorder buffer
  typedef struct packed {
    logic                           valid;
    core_cfg_pkg::arch_idx_t         arn;    // arch register being retired into
    core_cfg_pkg::reg_idx_t          prn;    // rename register that held the result
    logic [core_cfg_pkg::xlen-1:0]  value;
  } commit_t;

endpackage

/* source/free_pool.sv */
`timescale 1ns/100ps

module free_pool #(
  parameter int num_rename_regs = core_cfg_pkg::num_rename
) (
  input  logic                       global_bus,
  input  logic                       rst_n,
  input  logic [num_rename_regs-1:0] alloc_mask,    // bit r is rename register num_arch + r
  input  logic [num_rename_regs-1:0] release_mask,
  output core_cfg_pkg::reg_idx_t     pick0,
  output core_cfg_pkg::reg_idx_t     pick1,
  output logic                       pick0_ok,
  output logic                       pick1_ok,
  output logic [5:0]                 free_count
);

  // a set bit means the rename register is available for allocation
  logic [num_rename_regs-1:0] free_map;

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      free_map <= '1;
    end else begin
      // an allocated register is never released in the same cycle, so the order is safe
      free_map <= (free_map & ~alloc_mask) | release_mask;
    end
  end

  // two lowest-first pickers in one pass over the bitmap
  always_comb begin
    pick0    = '0;
    pick1    = '0;
    pick0_ok = 1'b0;
    pick1_ok = 1'b0;
    for (int r = 0; r < num_rename_regs; r++) begin
      if (free_map[r]) begin
        if (!pick0_ok) begin
          pick0_ok = 1'b1;
          pick0    = core_cfg_pkg::reg_idx_t'(core_cfg_pkg::num_arch + r);
        end else if (!pick1_ok) begin
          pick1_ok = 1'b1;
          pick1    = core_cfg_pkg::reg_idx_t'(core_cfg_pkg::num_arch + r);
        end
      end
    end
  end

  // population count of the bitmap, at most 32 so six bits are enough
  always_comb begin
    free_count = '0;
    for (int r = 0; r < num_rename_regs; r++) begin
      free_count = free_count + 6'(free_map[r]);
    end
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file #(
  parameter int num_rename_regs = core_cfg_pkg::num_rename
) (
  input  logic                          global_bus,
  input  logic                          rst_n,
  input  rename_bus_pkg::rename_req_t   rename_req [2],
  output rename_bus_pkg::rename_rsp_t   rename_rsp [2],
  input  rename_bus_pkg::wb_t           wb [2],
  input  rename_bus_pkg::commit_t       commit [2],
  input  logic                          spec_clear,
  input  logic                          spec_flush,
  input  core_cfg_pkg::reg_idx_t        pick0,
  input  core_cfg_pkg::reg_idx_t        pick1,
  input  logic                          pick0_ok,
  input  logic                          pick1_ok,
  output logic [num_rename_regs-1:0]    alloc_mask,
  output logic [num_rename_regs-1:0]    release_mask
);

  localparam int num_regs = core_cfg_pkg::num_arch + num_rename_regs;

  // map is only meaningful for arch entries and valid only for rename entries;
  // a map of zero means no mapping since rename registers start at num_arch
  typedef struct packed {
    logic [core_cfg_pkg::xlen-1:0] value;
    core_cfg_pkg::reg_idx_t         map;
    logic                          valid;
    logic                          tag;   // written under the current branch
  } entry_t;

  entry_t regs [num_regs];

  logic                   grant [2];
  core_cfg_pkg::reg_idx_t pd [2];

  // position of a rename register inside the free bitmap
  function automatic int rn_off(input core_cfg_pkg::reg_idx_t r);
    return int'(r) - core_cfg_pkg::num_arch;
  endfunction

  // operand lookup through the arch mapping, no writeback bypass
  function automatic rename_bus_pkg::operand_t lookup(input core_cfg_pkg::arch_idx_t a);
    rename_bus_pkg::operand_t op;
    core_cfg_pkg::reg_idx_t   m;
    m = regs[a].map;
    if (m == '0) begin
      op.ready = 1'b1;
      op.tag   = core_cfg_pkg::reg_idx_t'(a);
      op.value = regs[a].value;
    end else begin
      op.ready = regs[m].valid;
      op.tag   = m;
      op.value = regs[m].value;
    end
    return op;
  endfunction

  // port 1 needs the second free register only when port 0 already took the first
  always_comb begin
    grant[0] = rename_req[0].valid && !spec_flush && pick0_ok;
    grant[1] = rename_req[1].valid && !spec_flush && (grant[0] ? pick1_ok : pick0_ok);
    pd[0]    = grant[0] ? pick0 : '0;
    if (grant[1]) begin
      pd[1] = grant[0] ? pick1 : pick0;
    end else begin
      pd[1] = '0;
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rename_rsp[p].grant = grant[p];
      rename_rsp[p].pd    = pd[p];
      rename_rsp[p].src1  = lookup(rename_req[p].rs1);
      rename_rsp[p].src2  = lookup(rename_req[p].rs2);
    end
    // port 1 is younger, so it must wait on a register port 0 renames this cycle
    if (grant[0] && rename_req[1].rs1 == rename_req[0].rd) begin
      rename_rsp[1].src1 = '{ready: 1'b0, tag: pd[0], value: '0};
    end
    if (grant[0] && rename_req[1].rs2 == rename_req[0].rd) begin
      rename_rsp[1].src2 = '{ready: 1'b0, tag: pd[0], value: '0};
    end
  end

  // masks follow the same grant and commit decisions as the array update below
  always_comb begin
    alloc_mask   = '0;
    release_mask = '0;
    for (int p = 0; p < 2; p++) begin
      if (grant[p]) alloc_mask[rn_off(pd[p])] = 1'b1;
    end
    for (int c = 0; c < 2; c++) begin
      if (commit[c].valid) release_mask[rn_off(commit[c].prn)] = 1'b1;
    end
    if (spec_flush) begin
      for (int r = 0; r < num_rename_regs; r++) begin
        if (regs[core_cfg_pkg::num_arch + r].tag) release_mask[r] = 1'b1;
      end
    end
  end

  // later statements take priority, so a rename overrides a commit on the same rd
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (wb[w].valid) begin
          regs[wb[w].pd].value <= wb[w].value;
          regs[wb[w].pd].valid <= 1'b1;
        end
      end

      for (int c = 0; c < 2; c++) begin
        if (commit[c].valid) begin
          regs[commit[c].arn].value <= commit[c].value;
          // a newer rename of the same arch register keeps its mapping
          if (regs[commit[c].arn].map == commit[c].prn) begin
            regs[commit[c].arn].map <= '0;
            regs[commit[c].arn].tag <= 1'b0;
          end
          regs[commit[c].prn] <= '0;
        end
      end

      if (spec_flush) begin
        for (int i = 0; i < core_cfg_pkg::num_arch; i++) begin
          if (regs[i].tag) begin
            regs[i].map <= '0;   // falls back to the committed value
            regs[i].tag <= 1'b0;
          end
        end
        for (int i = core_cfg_pkg::num_arch; i < num_regs; i++) begin
          if (regs[i].tag) regs[i] <= '0;
        end
      end else if (spec_clear) begin
        for (int i = 0; i < num_regs; i++) begin
          regs[i].tag <= 1'b0;
        end
      end

      // renames come last so a spec rename in a clear cycle keeps its tag
      for (int p = 0; p < 2; p++) begin
        if (grant[p]) begin
          regs[rename_req[p].rd].map <= pd[p];
          regs[rename_req[p].rd].tag <= rename_req[p].spec;
          regs[pd[p]]                <= '{value: '0, map: '0, valid: 1'b0,
                                          tag: rename_req[p].spec};
        end
      end
    end
  end

endmodule

/* source/rename_regfile_top.sv */
`timescale 1ns/100ps

module rename_regfile_top #(
  parameter int num_rename_regs = core_cfg_pkg::num_rename   // at most 32
) (
  input  logic                        global_bus,
  input  logic                        rst_n,
  input  rename_bus_pkg::rename_req_t rename_req [2],
  output rename_bus_pkg::rename_rsp_t rename_rsp [2],
  input  rename_bus_pkg::wb_t         wb [2],
  input  rename_bus_pkg::commit_t     commit [2],
  input  logic                        spec_clear,
  input  logic                        spec_flush,
  output logic [5:0]                  free_count
);

  // lowest free rename registers offered to the grant logic
  core_cfg_pkg::reg_idx_t pick0;
  core_cfg_pkg::reg_idx_t pick1;
  logic                   pick0_ok;
  logic                   pick1_ok;

  // bitmap updates, one bit per rename register
  logic [num_rename_regs-1:0] alloc_mask;
  logic [num_rename_regs-1:0] release_mask;

  register_file #(
    .num_rename_regs (num_rename_regs)
  ) u_register_file (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .rename_req   (rename_req),
    .rename_rsp   (rename_rsp),
    .wb           (wb),
    .commit       (commit),
    .spec_clear   (spec_clear),
    .spec_flush   (spec_flush),
    .pick0        (pick0),
    .pick1        (pick1),
    .pick0_ok     (pick0_ok),
    .pick1_ok     (pick1_ok),
    .alloc_mask   (alloc_mask),
    .release_mask (release_mask)
  );

  free_pool #(
    .num_rename_regs (num_rename_regs)
  ) u_free_pool (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .alloc_mask   (alloc_mask),
    .release_mask (release_mask),
    .pick0        (pick0),
    .pick1        (pick1),
    .pick0_ok     (pick0_ok),
    .pick1_ok     (pick1_ok),
    .free_count   (free_count)
  );

endmodule

/* tests/rename_sva.sv */
`timescale 1ns/100ps

module rename_sva_checker #(
  parameter int num_rename_regs = core_cfg_pkg::num_rename
) (
  input logic                        global_bus,
  input logic                        rst_n,
  input rename_bus_pkg::rename_rsp_t rename_rsp [2],
  input logic                        spec_flush,
  input logic [5:0]                  free_count
);

  // a lone free register can serve only one port
  single_free_one_grant: assert property (@(posedge global_bus) disable iff (!rst_n)
    (free_count == 6'd1 && rename_rsp[1].grant) |-> !rename_rsp[0].grant)
    else $error("both ports granted with a single free rename register");

  no_grant_in_flush: assert property (@(posedge global_bus) disable iff (!rst_n)
    spec_flush |-> (!rename_rsp[0].grant && !rename_rsp[1].grant))
    else $error("rename granted during a flush");

  count_in_range: assert property (@(posedge global_bus) disable iff (!rst_n)
    free_count <= 6'(num_rename_regs))
    else $error("free count above the number of rename registers");

  // two grants in one cycle must never share a register
  distinct_pd: assert property (@(posedge global_bus) disable iff (!rst_n)
    (rename_rsp[0].grant && rename_rsp[1].grant) |-> rename_rsp[0].pd != rename_rsp[1].pd)
    else $error("both ports granted the same rename register");

  empty_pool_no_grant: assert property (@(posedge global_bus) disable iff (!rst_n)
    (free_count == 6'd0) |-> (!rename_rsp[0].grant && !rename_rsp[1].grant))
    else $error("rename granted with no free register");

endmodule

/* tests/rename_tb.sv */
`timescale 1ns/100ps

module rename_tb;

  localparam int nr = core_cfg_pkg::num_rename;
  localparam int na = core_cfg_pkg::num_arch;
  localparam int xl = core_cfg_pkg::xlen;
  localparam int reset_cycles = 3;
  localparam int directed_cycles = 80;
  localparam int random_cycles = 400;
  localparam int max_cycles = reset_cycles + directed_cycles + random_cycles + 50;

  // one in-flight instruction as the reorder buffer sees it
  typedef struct packed {
    core_cfg_pkg::arch_idx_t arn;
    core_cfg_pkg::reg_idx_t  prn;
    logic                    spec;
    logic                    done;   // result already written back
    logic [xl-1:0]           value;
  } inflight_t;

  logic                        global_bus;
  logic                        rst_n;
  rename_bus_pkg::rename_req_t rename_req [2];
  rename_bus_pkg::rename_rsp_t rename_rsp [2];
  rename_bus_pkg::wb_t         wb [2];
  rename_bus_pkg::commit_t     commit [2];
  logic                        spec_clear;
  logic                        spec_flush;
  logic [5:0]                  free_count;

  // reference state with the arch side and the rename side kept apart
  logic [xl-1:0]          arch_val [na];
  core_cfg_pkg::reg_idx_t arch_map [na];
  logic                   arch_mapped [na];
  logic                   arch_spec [na];
  logic [xl-1:0]          ren_val [nr];
  logic                   ren_rdy [nr];
  logic                   ren_spec [nr];
  logic [nr-1:0]          ren_free;   // bit r stands for register na + r

  inflight_t rob [$];
  int        seed;
  int        errors;
  int        checks;
  int        cycle_count;

  rename_regfile_top #(
    .num_rename_regs (nr)
  ) DUT (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .rename_req (rename_req),
    .rename_rsp (rename_rsp),
    .wb         (wb),
    .commit     (commit),
    .spec_clear (spec_clear),
    .spec_flush (spec_flush),
    .free_count (free_count)
  );

  bind rename_regfile_top rename_sva_checker #(
    .num_rename_regs (num_rename_regs)
  ) u_sva (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .rename_rsp (rename_rsp),
    .spec_flush (spec_flush),
    .free_count (free_count)
  );

  always #20 global_bus = ~global_bus;

  function automatic int roll(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic rename_bus_pkg::rename_req_t make_req(input int rd, input int rs1,
                                                           input int rs2, input bit spec);
    return '{valid: 1'b1, rd: 5'(rd), rs1: 5'(rs1), rs2: 5'(rs2), spec: spec};
  endfunction

  function automatic rename_bus_pkg::wb_t make_wb(input int pd, input logic [xl-1:0] v);
    return '{valid: 1'b1, pd: 6'(pd), value: v};
  endfunction

  function automatic rename_bus_pkg::commit_t make_commit(input int arn, input int prn,
                                                          input logic [xl-1:0] v);
    return '{valid: 1'b1, arn: 5'(arn), prn: 6'(prn), value: v};
  endfunction

  // an unmapped arch register is always ready with its committed value
  function automatic rename_bus_pkg::operand_t model_operand(input core_cfg_pkg::arch_idx_t a);
    rename_bus_pkg::operand_t op;
    int k;
    op.ready = 1'b1;
    op.tag   = core_cfg_pkg::reg_idx_t'(a);
    op.value = arch_val[a];
    if (arch_mapped[a]) begin
      k        = int'(arch_map[a]) - na;
      op.ready = ren_rdy[k];
      op.tag   = arch_map[a];
      op.value = ren_val[k];
    end
    return op;
  endfunction

  function automatic void expected_rsp(output rename_bus_pkg::rename_rsp_t e0,
                                       output rename_bus_pkg::rename_rsp_t e1,
                                       output logic [5:0] fc);
    int nfree;
    int lo0;
    int lo1;
    rename_bus_pkg::operand_t fwd;
    nfree = 0;
    lo0 = 0;
    lo1 = 0;
    // scanning downward leaves the two lowest free registers at the end
    for (int r = nr - 1; r >= 0; r--) begin
      if (ren_free[r]) begin
        nfree++;
        lo1 = lo0;
        lo0 = na + r;
      end
    end
    e0 = '0;
    e1 = '0;
    e0.grant = rename_req[0].valid && !spec_flush && nfree >= 1;
    e1.grant = rename_req[1].valid && !spec_flush && nfree >= (e0.grant ? 2 : 1);
    e0.pd    = 6'(lo0);
    e1.pd    = e0.grant ? 6'(lo1) : 6'(lo0);
    e0.src1  = model_operand(rename_req[0].rs1);
    e0.src2  = model_operand(rename_req[0].rs2);
    e1.src1  = model_operand(rename_req[1].rs1);
    e1.src2  = model_operand(rename_req[1].rs2);
    fwd.ready = 1'b0;   // port 0's result cannot exist yet
    fwd.tag   = e0.pd;
    fwd.value = '0;
    if (e0.grant && rename_req[1].rs1 == rename_req[0].rd) e1.src1 = fwd;
    if (e0.grant && rename_req[1].rs2 == rename_req[0].rd) e1.src2 = fwd;
    fc = 6'(nfree);
  endfunction

  task automatic check_field(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic compare_port(input int p, input rename_bus_pkg::rename_rsp_t e);
    string n;
    n = $sformatf("rename_rsp[%0d]", p);
    check_field({n, ".grant"}, 64'(e.grant), 64'(rename_rsp[p].grant));
    if (e.grant) check_field({n, ".pd"}, 64'(e.pd), 64'(rename_rsp[p].pd));
    check_field({n, ".src1"}, 64'(e.src1), 64'(rename_rsp[p].src1));
    check_field({n, ".src2"}, 64'(e.src2), 64'(rename_rsp[p].src2));
  endtask

  // conditions look at the state before the edge, renames land last
  task automatic apply_edge(input rename_bus_pkg::rename_rsp_t e0,
                            input rename_bus_pkg::rename_rsp_t e1);
    core_cfg_pkg::reg_idx_t old_map [na];
    logic old_mapped [na];
    logic old_aspec [na];
    logic old_rspec [nr];
    logic gr [2];
    core_cfg_pkg::reg_idx_t pd [2];
    inflight_t ent;
    int k;
    if (!rst_n) begin
      for (int a = 0; a < na; a++) begin
        arch_val[a]    = '0;
        arch_map[a]    = '0;
        arch_mapped[a] = 1'b0;
        arch_spec[a]   = 1'b0;
      end
      for (int r = 0; r < nr; r++) begin
        ren_val[r]  = '0;
        ren_rdy[r]  = 1'b0;
        ren_spec[r] = 1'b0;
      end
      ren_free = '1;
      rob.delete();
    end else begin
      old_map    = arch_map;
      old_mapped = arch_mapped;
      old_aspec  = arch_spec;
      old_rspec  = ren_spec;
      for (int w = 0; w < 2; w++) begin
        if (wb[w].valid) begin
          k = int'(wb[w].pd) - na;
          ren_val[k] = wb[w].value;
          ren_rdy[k] = 1'b1;
        end
      end
      for (int c = 0; c < 2; c++) begin
        if (commit[c].valid) begin
          k = int'(commit[c].prn) - na;
          arch_val[commit[c].arn] = commit[c].value;
          if (old_mapped[commit[c].arn] && old_map[commit[c].arn] == commit[c].prn) begin
            arch_mapped[commit[c].arn] = 1'b0;
            arch_spec[commit[c].arn]   = 1'b0;
          end
          ren_val[k]  = '0;
          ren_rdy[k]  = 1'b0;
          ren_spec[k] = 1'b0;
          ren_free[k] = 1'b1;
        end
      end
      if (spec_flush) begin
        for (int a = 0; a < na; a++) begin
          if (old_aspec[a]) begin
            arch_mapped[a] = 1'b0;
            arch_spec[a]   = 1'b0;
          end
        end
        for (int r = 0; r < nr; r++) begin
          if (old_rspec[r]) begin
            ren_val[r]  = '0;
            ren_rdy[r]  = 1'b0;
            ren_spec[r] = 1'b0;
            ren_free[r] = 1'b1;
          end
        end
      end else if (spec_clear) begin
        for (int a = 0; a < na; a++) arch_spec[a] = 1'b0;
        for (int r = 0; r < nr; r++) ren_spec[r] = 1'b0;
      end
      gr[0] = e0.grant;
      gr[1] = e1.grant;
      pd[0] = e0.pd;
      pd[1] = e1.pd;
      for (int p = 0; p < 2; p++) begin
        if (gr[p]) begin
          k = int'(pd[p]) - na;
          arch_mapped[rename_req[p].rd] = 1'b1;
          arch_map[rename_req[p].rd]    = pd[p];
          arch_spec[rename_req[p].rd]   = rename_req[p].spec;
          ren_val[k]  = '0;
          ren_rdy[k]  = 1'b0;
          ren_spec[k] = rename_req[p].spec;
          ren_free[k] = 1'b0;
          ent = '{arn: rename_req[p].rd, prn: pd[p], spec: rename_req[p].spec,
                  done: 1'b0, value: '0};
          rob.push_back(ent);
        end
      end
    end
  endtask

  // samples 1 ns before the rising edge, then advances the model past it
  always begin
    rename_bus_pkg::rename_rsp_t e0;
    rename_bus_pkg::rename_rsp_t e1;
    logic [5:0] fc;
    @(negedge global_bus);
    #19;
    if (rst_n) begin
      expected_rsp(e0, e1, fc);
      compare_port(0, e0);
      compare_port(1, e1);
      check_field("free_count", 64'(fc), 64'(free_count));
    end
    apply_edge(e0, e1);
  end

  always @(posedge global_bus) begin
    cycle_count++;
    if (cycle_count > max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic clear_inputs();
    for (int p = 0; p < 2; p++) begin
      rename_req[p] = '0;
      wb[p]         = '0;
      commit[p]     = '0;
    end
    spec_clear = 1'b0;
    spec_flush = 1'b0;
  endtask

  task automatic next_cycle();
    @(negedge global_bus);
    clear_inputs();
  endtask

  task automatic restart();
    next_cycle();
    rst_n = 1'b0;
    repeat (reset_cycles) @(negedge global_bus);
    rst_n = 1'b1;
  endtask

  task automatic drive_random_cycle();
    int n;
    int k;
    logic [xl-1:0] v;
    next_cycle();
    n = 0;
    // in-order retirement, never past an unresolved speculative instruction
    while (n < 2 && rob.size() > 0 && rob[0].done && !rob[0].spec && roll(4) != 0) begin
      commit[n] = make_commit(rob[0].arn, rob[0].prn, rob[0].value);
      void'(rob.pop_front());
      n++;
    end
    for (int w = 0; w < 2; w++) begin
      if (rob.size() > 0 && roll(2) == 1) begin
        k = roll(rob.size());
        if (!rob[k].done) begin
          v = $random(seed);
          rob[k].done  = 1'b1;
          rob[k].value = v;
          wb[w] = make_wb(rob[k].prn, v);
        end
      end
    end
    for (int p = 0; p < 2; p++) begin
      rename_req[p] = make_req(roll(32), roll(32), roll(32), roll(4) == 0);
      rename_req[p].valid = roll(4) != 0;
    end
    k = roll(24);
    spec_flush = (k == 0 || k == 2);
    spec_clear = (k == 1 || k == 2);
    if (spec_flush) begin
      for (int i = rob.size() - 1; i >= 0; i--) begin
        if (rob[i].spec) rob.delete(i);
      end
    end else if (spec_clear) begin
      for (int i = 0; i < rob.size(); i++) rob[i].spec = 1'b0;
    end
  endtask

  initial begin
    seed        = 32'h4793;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    global_bus  = 1'b0;
    rst_n       = 1'b0;
    clear_inputs();
    repeat (reset_cycles) @(negedge global_bus);
    rst_n = 1'b1;

    // sweep every arch register through the lookups with no request valid
    for (int a = 0; a < na; a += 2) begin
      next_cycle();
      rename_req[0] = make_req(0, a, a + 1, 0);
      rename_req[1] = make_req(0, a + 1, a, 0);
      rename_req[0].valid = 1'b0;
      rename_req[1].valid = 1'b0;
    end

    for (int i = 0; i < 16; i++) begin
      next_cycle();
      rename_req[0] = make_req(i, i, i + 1, 0);
      rename_req[1] = make_req(i + 16, i, 31 - i, 0);
    end
    next_cycle();
    rename_req[0] = make_req(1, 2, 3, 0);   // pool is empty, both refused
    rename_req[1] = make_req(4, 5, 6, 0);
    next_cycle();
    commit[0] = make_commit(0, 32, 32'h0000_1234);
    next_cycle();
    rename_req[0] = make_req(7, 0, 16, 0);  // the single free register goes to port 0
    rename_req[1] = make_req(8, 0, 7, 0);
    restart();

    next_cycle();
    rename_req[0] = make_req(1, 0, 0, 0);
    rename_req[1] = make_req(2, 1, 3, 0);   // rs1 waits on port 0's new register
    next_cycle();
    rename_req[0] = make_req(3, 1, 2, 0);
    wb[0] = make_wb(32, 32'hA5A5_0001);     // lookups this cycle still see it pending
    next_cycle();
    rename_req[0] = make_req(4, 1, 2, 0);
    wb[1] = make_wb(33, 32'h5A5A_0002);
    next_cycle();
    rename_req[0] = make_req(2, 1, 2, 0);   // remap r2 before its older result retires
    next_cycle();
    commit[0] = make_commit(1, 32, 32'hA5A5_0001);
    commit[1] = make_commit(2, 33, 32'h5A5A_0002);
    next_cycle();
    rename_req[0] = make_req(5, 1, 2, 0);   // register 32 is the lowest pick again

    next_cycle();
    rename_req[0] = make_req(6, 6, 7, 1);
    rename_req[1] = make_req(7, 6, 7, 1);
    next_cycle();
    spec_clear = 1'b1;
    rename_req[0] = make_req(8, 6, 7, 1);   // renamed in the clear cycle, so still tagged
    next_cycle();
    rename_req[0] = make_req(9, 6, 7, 1);
    rename_req[1] = make_req(10, 8, 9, 0);
    next_cycle();
    spec_flush = 1'b1;
    spec_clear = 1'b1;
    rename_req[0] = make_req(11, 6, 8, 0);
    next_cycle();
    rename_req[0] = make_req(0, 6, 9, 0);
    rename_req[1] = make_req(0, 8, 10, 0);
    rename_req[0].valid = 1'b0;
    rename_req[1].valid = 1'b0;
    restart();

    repeat (random_cycles) drive_random_cycle();
    next_cycle();
    next_cycle();

    $display("Summary: %0d mismatches in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
source/core_cfg_pkg.sv
source/rename_bus_pkg.sv
source/free_pool.sv
source/register_file.sv
source/rename_regfile_top.sv
tests/rename_sva.sv
tests/rename_tb.sv

/* Makefile */
TOP := rename_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

obj_dir/V$(TOP): build.f $(wildcard source/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	  -f build.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
	  -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
